// ==== bench/uniboard_patterns.txt ====
# kind n_body body0..body5 | hdr0 addr size data duty_l duty_r (all hex except n_body)
# restart: first two body bytes go out before a second start byte and must be dropped
write   3 02 00 40 00 00 00  02 00 1 00000040 40 00
write   3 02 01 c0 00 00 00  02 01 1 000000c0 40 c0
read    2 82 00 00 00 00 00  82 00 1 00000040 40 c0
read    2 82 01 00 00 00 00  82 01 1 000000c0 40 c0
write   3 02 00 17 00 00 00  02 00 1 00000017 17 c0
write   3 02 01 1b 00 00 00  02 01 1 0000001b 17 1b
write   3 02 00 01 00 00 00  02 00 1 00000001 01 1b
read    2 82 05 00 00 00 00  82 05 0 00000000 01 1b
read    2 89 00 00 00 00 00  89 00 0 00000000 01 1b
write   6 09 03 11 22 33 44  09 03 0 00000000 01 1b
short   1 82 00 00 00 00 00  00 00 0 00000000 01 1b
short   0 00 00 00 00 00 00  00 00 0 00000000 01 1b
read    2 82 00 00 00 00 00  82 00 1 00000001 01 1b
restart 4 02 01 82 00 00 00  82 00 1 00000001 01 1b
read    2 82 17 00 00 00 00  82 17 0 00000000 01 1b
read    2 82 1b 00 00 00 00  82 1b 0 00000000 01 1b
write   4 02 00 00 ff 00 00  02 00 1 00000000 00 1b
write   3 02 00 80 00 00 00  02 00 1 00000080 80 1b
read    2 82 01 00 00 00 00  82 01 1 0000001b 80 1b

// ==== bench/uniboard_tb.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module uniboard_tb;

	logic clk_12MHz;
	logic reset;
	logic rx_line;
	logic tx_line;
	logic pwm_l;
	logic pwm_r;

	// Pattern lines, comments and blank lines removed
	string lines[$];
	int line_total = 0;
	// Unescaped reply payload, header first
	uniboard_pkg::byte_t reply_bytes[$];

	uniboard_top uut (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.uart_rx(rx_line),
		.uart_tx(tx_line),
		.motor_pwm_l(pwm_l),
		.motor_pwm_r(pwm_r)
	);

	// 50 MHz style 20 ns period
	initial
	begin
		clk_12MHz = 1'b0;
		forever #10 clk_12MHz = ~clk_12MHz;
	end

	task automatic report_failure(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("Test failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_byte(input uniboard_pkg::byte_t actual,
		input uniboard_pkg::byte_t expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %02h, expected %02h", what, actual, expected));
	endtask

	task automatic check_size(input uniboard_pkg::reg_size_t actual,
		input uniboard_pkg::reg_size_t expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %0d, expected %0d", what, actual, expected));
	endtask

	task automatic check_reg(input uniboard_pkg::reg_data_t actual,
		input uniboard_pkg::reg_data_t expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %08h, expected %08h", what, actual, expected));
	endtask

	task automatic check_level(input bit actual, input bit expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %0b, expected %0b", what, actual, expected));
	endtask

	function automatic bit is_protocol_byte(input uniboard_pkg::byte_t value);
		return value == `UB_START_BYTE || value == `UB_END_BYTE || value == `UB_ESC_BYTE;
	endfunction

	// Host side 8N1, called on a falling edge
	task automatic send_byte(input uniboard_pkg::byte_t value);
		rx_line = 1'b0;
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		// LSB first
		for (int i = 0; i < 8; i++)
		begin
			rx_line = value[i];
			repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		end
		rx_line = 1'b1;
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
	endtask

	// Protocol bytes in the body go out behind an escape
	task automatic send_payload(input uniboard_pkg::byte_t value);
		if (is_protocol_byte(value))
			send_byte(`UB_ESC_BYTE);
		send_byte(value);
	endtask

	task automatic receive_byte(output uniboard_pkg::byte_t value);
		// Wait for the start bit
		while (tx_line !== 1'b0)
			@(negedge clk_12MHz);
		repeat (`UB_BAUD_DIV / 2) @(negedge clk_12MHz);
		check_level(tx_line, 1'b0, "reply start bit");
		// Mid-bit samples from here on
		for (int i = 0; i < 8; i++)
		begin
			repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
			value[i] = tx_line;
		end
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		check_level(tx_line, 1'b1, "reply stop bit");
	endtask

	task automatic receive_frame();
		uniboard_pkg::byte_t value;
		bit escaped;
		bit done;
		reply_bytes.delete();
		escaped = 1'b0;
		done = 1'b0;
		receive_byte(value);
		check_byte(value, `UB_START_BYTE, "reply start byte");
		while (!done)
		begin
			receive_byte(value);
			if (escaped)
			begin
				reply_bytes.push_back(value);
				escaped = 1'b0;
			end
			else if (value == `UB_ESC_BYTE)
				escaped = 1'b1;
			else if (value == `UB_END_BYTE)
				done = 1'b1;
			else if (value == `UB_START_BYTE)
				abort_run("reply holds an unescaped start byte");
			else
				reply_bytes.push_back(value);
			// Header plus at most four data bytes
			if (reply_bytes.size() > 6)
				abort_run("reply runs past six payload bytes");
		end
	endtask

	// No reply may start after an abandoned frame
	task automatic check_silence();
		repeat (40 * `UB_BAUD_DIV)
		begin
			@(negedge clk_12MHz);
			check_level(tx_line, 1'b1, "idle line after short frame");
		end
	endtask

	// One full PWM period, high cycles are duty times divider
	task automatic measure_duty(input uniboard_pkg::byte_t duty_l,
		input uniboard_pkg::byte_t duty_r);
		uniboard_pkg::reg_data_t high_l;
		uniboard_pkg::reg_data_t high_r;
		high_l = '0;
		high_r = '0;
		repeat (256 * `UB_PWM_DIV)
		begin
			@(negedge clk_12MHz);
			high_l = high_l + uniboard_pkg::reg_data_t'(pwm_l);
			high_r = high_r + uniboard_pkg::reg_data_t'(pwm_r);
		end
		check_reg(high_l, uniboard_pkg::reg_data_t'(duty_l) * `UB_PWM_DIV, "left PWM high cycles");
		check_reg(high_r, uniboard_pkg::reg_data_t'(duty_r) * `UB_PWM_DIV,
			"right PWM high cycles");
	endtask

	task automatic run_line(input string line);
		logic [63:0] kind;
		int n;
		int fields;
		uniboard_pkg::byte_t body [6];
		uniboard_pkg::byte_t exp_hdr0;
		uniboard_pkg::reg_addr_t exp_addr;
		uniboard_pkg::reg_size_t exp_size;
		uniboard_pkg::reg_data_t exp_data;
		uniboard_pkg::byte_t exp_duty_l;
		uniboard_pkg::byte_t exp_duty_r;
		uniboard_pkg::reg_data_t got_data;
		fields = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h", kind, n,
			body[0], body[1], body[2], body[3], body[4], body[5],
			exp_hdr0, exp_addr, exp_size, exp_data, exp_duty_l, exp_duty_r);
		if (fields != 14 || n < 0 || n > 6)
			abort_run($sformatf("malformed pattern line: %s", line));
		if (kind != "write" && kind != "read" && kind != "short" && kind != "restart")
			abort_run($sformatf("unknown transaction kind in line: %s", line));
		send_byte(`UB_START_BYTE);
		for (int i = 0; i < n; i++)
		begin
			// Restart lines: first two bytes sit ahead of a second start byte
			if (kind == "restart" && i == 2)
				send_byte(`UB_START_BYTE);
			send_payload(body[i]);
		end
		send_byte(`UB_END_BYTE);
		if (kind == "short")
			check_silence();
		else
		begin
			receive_frame();
			if (reply_bytes.size() < 2)
				abort_run("reply is missing its header bytes");
			check_byte(reply_bytes[0], exp_hdr0, "reply header byte");
			check_byte(reply_bytes[1], exp_addr, "reply address byte");
			check_size(uniboard_pkg::reg_size_t'(reply_bytes.size() - 2), exp_size, "reply size");
			// Data comes least significant byte first
			got_data = '0;
			for (int i = 2; i < reply_bytes.size(); i++)
				got_data[8*(i-2) +: 8] = reply_bytes[i];
			check_reg(got_data, exp_data, "reply data");
		end
		measure_duty(exp_duty_l, exp_duty_r);
	endtask

	initial
	begin
		int fd;
		string line;
		reset = 1'b1;
		rx_line = 1'b1;
		fd = $fopen("bench/uniboard_patterns.txt", "r");
		if (fd == 0)
			abort_run("cannot open bench/uniboard_patterns.txt");
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		if (lines.size() == 0)
			abort_run("pattern file holds no transactions");
		line_total = lines.size();
		repeat (5) @(negedge clk_12MHz);
		reset = 1'b0;
		// Idle line for a bit before the first frame
		repeat (`UB_BAUD_DIV) @(negedge clk_12MHz);
		foreach (lines[i])
			run_line(lines[i]);
		$display("Test passed");
		$finish;
	end

	// 400 bit times per line plus a margin for reset
	initial
	begin
		wait (line_total != 0);
		#((longint'(line_total) * 400 + 20) * `UB_BAUD_DIV * 20);
		$display("Test failed");
		$fatal(1, "Watchdog expired, a reply never finished");
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the uniboard testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module uniboard_tb -f vlog.f -o uniboard_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/uniboard_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0

// ==== src/command_engine.sv ====
`timescale 1ns/100ps

module command_engine (
	input logic clk_12MHz,
	input logic reset,
	input logic cmd_req,
	output logic cmd_ack,
	input logic cmd_read,
	input uniboard_pkg::periph_t cmd_periph,
	input uniboard_pkg::reg_addr_t cmd_addr,
	input uniboard_pkg::reg_data_t cmd_data,
	output uniboard_pkg::periph_t bus_periph,
	output uniboard_pkg::reg_addr_t bus_addr,
	output uniboard_pkg::reg_data_t bus_wdata,
	output logic bus_rw,
	output logic bus_select,
	input uniboard_pkg::reg_data_t bus_rdata,
	input uniboard_pkg::reg_size_t bus_size,
	output logic reply_req,
	input logic reply_ack,
	output uniboard_pkg::byte_t reply_hdr0,
	output uniboard_pkg::reg_addr_t reply_addr,
	output uniboard_pkg::reg_data_t reply_data,
	output uniboard_pkg::reg_size_t reply_size
);

	uniboard_pkg::engine_state_t state;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= uniboard_pkg::eng_idle;
			cmd_ack <= 1'b0;
			bus_select <= 1'b0;
			bus_rw <= 1'b1;
			reply_req <= 1'b0;
		end
		else
		begin
			case (state)
				uniboard_pkg::eng_idle:
				begin
					if (cmd_req)
					begin
						bus_periph <= cmd_periph;
						bus_addr <= cmd_addr;
						bus_wdata <= cmd_data;
						bus_rw <= cmd_read;
						// First body byte, as the host sent it
						reply_hdr0 <= {cmd_read, cmd_periph};
						reply_addr <= cmd_addr;
						cmd_ack <= 1'b1;
						state <= uniboard_pkg::eng_ack;
					end
				end
				uniboard_pkg::eng_ack:
				begin
					if (!cmd_req)
					begin
						cmd_ack <= 1'b0;
						state <= reply_hdr0[7] ? uniboard_pkg::eng_rd_setup
							: uniboard_pkg::eng_wr_setup;
					end
				end
				uniboard_pkg::eng_wr_setup:
				begin
					bus_select <= 1'b1;
					state <= uniboard_pkg::eng_wr_sel1;
				end
				uniboard_pkg::eng_wr_sel1:
					state <= uniboard_pkg::eng_wr_sel2;
				uniboard_pkg::eng_wr_sel2:
				begin
					bus_select <= 1'b0;
					state <= uniboard_pkg::eng_wr_gap;
				end
				uniboard_pkg::eng_wr_gap:
				begin
					// Read back what was just written
					bus_rw <= 1'b1;
					state <= uniboard_pkg::eng_rd_setup;
				end
				uniboard_pkg::eng_rd_setup:
				begin
					bus_select <= 1'b1;
					state <= uniboard_pkg::eng_rd_sel1;
				end
				uniboard_pkg::eng_rd_sel1:
					state <= uniboard_pkg::eng_rd_sel2;
				uniboard_pkg::eng_rd_sel2:
				begin
					// Bus settled by the second select cycle
					reply_data <= bus_rdata;
					reply_size <= bus_size;
					bus_select <= 1'b0;
					reply_req <= 1'b1;
					state <= uniboard_pkg::eng_reply;
				end
				uniboard_pkg::eng_reply:
				begin
					if (reply_ack)
					begin
						reply_req <= 1'b0;
						state <= uniboard_pkg::eng_release;
					end
				end
				uniboard_pkg::eng_release:
				begin
					// Next command only once the encoder lets go
					if (!reply_ack)
						state <= uniboard_pkg::eng_idle;
				end
				default:
					state <= uniboard_pkg::eng_idle;
			endcase
		end
	end

	// Direction never flips under an active select
	assert property (@(posedge clk_12MHz) disable iff (reset)
		bus_select ##1 bus_select |-> $stable(bus_rw));

endmodule

// ==== src/frame_decoder.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module frame_decoder (
	input logic clk_12MHz,
	input logic reset,
	input uniboard_pkg::byte_t rx_byte,
	input logic rx_valid,
	output logic cmd_req,
	input logic cmd_ack,
	output logic cmd_read,
	output uniboard_pkg::periph_t cmd_periph,
	output uniboard_pkg::reg_addr_t cmd_addr,
	output uniboard_pkg::reg_data_t cmd_data
);

	uniboard_pkg::decoder_state_t state;
	uniboard_pkg::byte_t buffer [`UB_FRAME_BYTES];
	// Body bytes held so far
	logic [2:0] count;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= uniboard_pkg::dec_hunt;
			cmd_req <= 1'b0;
			count <= '0;
		end
		else
		begin
			case (state)
				uniboard_pkg::dec_hunt:
				begin
					// Everything but a start byte is noise here
					if (rx_valid && rx_byte == `UB_START_BYTE)
					begin
						count <= '0;
						state <= uniboard_pkg::dec_body;
					end
				end
				uniboard_pkg::dec_body:
				begin
					if (rx_valid)
					begin
						if (rx_byte == `UB_ESC_BYTE)
						begin
							state <= uniboard_pkg::dec_escaped;
						end
						else if (rx_byte == `UB_START_BYTE)
						begin
							// Restart, earlier bytes forgotten
							count <= '0;
						end
						else if (rx_byte == `UB_END_BYTE)
						begin
							if (count >= 3'd2)
							begin
								cmd_read <= buffer[0][7];
								cmd_periph <= buffer[0][6:0];
								cmd_addr <= buffer[1];
								// Data bytes not sent read as zero
								for (int i = 0; i < 4; i++)
									cmd_data[8*i +: 8] <= (count > i + 2) ? buffer[i + 2] : 8'h00;
								cmd_req <= 1'b1;
								state <= uniboard_pkg::dec_request;
							end
							else
							begin
								// No address, nothing to do
								state <= uniboard_pkg::dec_hunt;
							end
						end
						else if (count < `UB_FRAME_BYTES)
						begin
							buffer[count] <= rx_byte;
							count <= count + 3'd1;
						end
					end
				end
				uniboard_pkg::dec_escaped:
				begin
					// Taken literally, even a protocol byte
					if (rx_valid)
					begin
						if (count < `UB_FRAME_BYTES)
						begin
							buffer[count] <= rx_byte;
							count <= count + 3'd1;
						end
						state <= uniboard_pkg::dec_body;
					end
				end
				uniboard_pkg::dec_request:
				begin
					// Four-phase handshake, received bytes dropped meanwhile
					if (cmd_req && cmd_ack)
						cmd_req <= 1'b0;
					else if (!cmd_req && !cmd_ack)
						state <= uniboard_pkg::dec_hunt;
				end
				default:
					state <= uniboard_pkg::dec_hunt;
			endcase
		end
	end

	// Engine may latch at any point of the request
	assert property (@(posedge clk_12MHz) disable iff (reset)
		cmd_req ##1 cmd_req |-> $stable({cmd_read, cmd_periph, cmd_addr, cmd_data}));

endmodule

// ==== src/pwm_peripheral.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module pwm_peripheral (
	input logic clk_12MHz,
	input logic reset,
	input uniboard_pkg::periph_t bus_periph,
	input uniboard_pkg::reg_addr_t bus_addr,
	input uniboard_pkg::reg_data_t bus_wdata,
	input logic bus_rw,
	input logic bus_select,
	output uniboard_pkg::reg_data_t bus_rdata,
	output uniboard_pkg::reg_size_t bus_size,
	output logic pwm_left,
	output logic pwm_right
);

	logic sel;
	logic sel_q;
	uniboard_pkg::byte_t duty_left;
	uniboard_pkg::byte_t duty_right;
	logic [7:0] div_cnt;
	uniboard_pkg::byte_t pwm_cnt;

	assign sel = bus_select && (bus_periph == `UB_PWM_PERIPH);

	// Writes land on the rising edge of select
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			sel_q <= 1'b0;
			duty_left <= '0;
			duty_right <= '0;
		end
		else
		begin
			sel_q <= sel;
			if (sel && !sel_q && !bus_rw)
			begin
				case (bus_addr)
					8'd0: duty_left <= bus_wdata[7:0];
					8'd1: duty_right <= bus_wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	// Zero on the read bus unless selected for a read
	always_comb
	begin
		bus_rdata = '0;
		bus_size = '0;
		if (sel && bus_rw)
		begin
			case (bus_addr)
				8'd0:
				begin
					bus_rdata = {24'd0, duty_left};
					bus_size = 3'd1;
				end
				8'd1:
				begin
					bus_rdata = {24'd0, duty_right};
					bus_size = 3'd1;
				end
				default: ;
			endcase
		end
	end

	// Period of 256 steps, one step every UB_PWM_DIV cycles
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			div_cnt <= '0;
			pwm_cnt <= '0;
			pwm_left <= 1'b0;
			pwm_right <= 1'b0;
		end
		else
		begin
			if (div_cnt == 8'(`UB_PWM_DIV - 1))
			begin
				div_cnt <= '0;
				pwm_cnt <= pwm_cnt + 8'd1;
			end
			else
			begin
				div_cnt <= div_cnt + 8'd1;
			end
			// Duty 0 keeps the output low
			pwm_left <= (pwm_cnt < duty_left);
			pwm_right <= (pwm_cnt < duty_right);
		end
	end

endmodule

// ==== src/reply_encoder.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module reply_encoder (
	input logic clk_12MHz,
	input logic reset,
	input logic reply_req,
	output logic reply_ack,
	input uniboard_pkg::byte_t reply_hdr0,
	input uniboard_pkg::reg_addr_t reply_addr,
	input uniboard_pkg::reg_data_t reply_data,
	input uniboard_pkg::reg_size_t reply_size,
	output uniboard_pkg::byte_t tx_byte,
	output logic send,
	input logic busy
);

	uniboard_pkg::encoder_state_t state;
	// Position in frame: start, header, address, data, end
	logic [3:0] idx;
	logic [3:0] end_idx;
	logic [1:0] data_sel;
	uniboard_pkg::byte_t cur_byte;
	logic is_payload;
	logic is_special;
	// Escape already out for the current byte
	logic escape_sent;

	assign end_idx = {1'b0, reply_size} + 4'd3;
	// idx 3 maps to data byte 0
	assign data_sel = idx[1:0] + 2'd1;
	assign is_payload = (idx != 4'd0) && (idx != end_idx);
	assign is_special = (cur_byte == `UB_START_BYTE) || (cur_byte == `UB_END_BYTE)
		|| (cur_byte == `UB_ESC_BYTE);

	always_comb
	begin
		case (idx)
			4'd0: cur_byte = `UB_START_BYTE;
			4'd1: cur_byte = reply_hdr0;
			4'd2: cur_byte = reply_addr;
			default:
			begin
				if (idx == end_idx)
					cur_byte = `UB_END_BYTE;
				else
					cur_byte = reply_data[{data_sel, 3'b000} +: 8];
			end
		endcase
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= uniboard_pkg::enc_idle;
			reply_ack <= 1'b0;
			send <= 1'b0;
			idx <= '0;
			escape_sent <= 1'b0;
		end
		else
		begin
			case (state)
				uniboard_pkg::enc_idle:
				begin
					if (reply_req)
					begin
						idx <= '0;
						escape_sent <= 1'b0;
						state <= uniboard_pkg::enc_pick;
					end
				end
				uniboard_pkg::enc_pick:
				begin
					if (idx > end_idx)
					begin
						// End byte gone, release the engine
						reply_ack <= 1'b1;
						state <= uniboard_pkg::enc_ack;
					end
					else
					begin
						if (is_payload && is_special && !escape_sent)
						begin
							tx_byte <= `UB_ESC_BYTE;
							escape_sent <= 1'b1;
						end
						else
						begin
							tx_byte <= cur_byte;
							escape_sent <= 1'b0;
							idx <= idx + 4'd1;
						end
						send <= 1'b1;
						state <= uniboard_pkg::enc_send;
					end
				end
				uniboard_pkg::enc_send:
				begin
					// Transmitter took the byte
					if (busy)
					begin
						send <= 1'b0;
						state <= uniboard_pkg::enc_drain;
					end
				end
				uniboard_pkg::enc_drain:
				begin
					if (!busy)
						state <= uniboard_pkg::enc_pick;
				end
				uniboard_pkg::enc_ack:
				begin
					if (!reply_req)
					begin
						reply_ack <= 1'b0;
						state <= uniboard_pkg::enc_idle;
					end
				end
				default:
					state <= uniboard_pkg::enc_idle;
			endcase
		end
	end

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module uart_rx (
	input logic clk_12MHz,
	input logic reset,
	input logic rx,
	output uniboard_pkg::byte_t rx_byte,
	output logic rx_valid
);

	logic rx_meta;
	logic rx_sync;
	logic active;
	logic [15:0] baud_cnt;
	logic [3:0] bit_idx;
	uniboard_pkg::byte_t shift_reg;

	// Line idles high, so the synchronizer resets to 1
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			active <= 1'b0;
			rx_valid <= 1'b0;
			baud_cnt <= '0;
			bit_idx <= '0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (!active)
			begin
				// Falling edge of start bit, first sample half a bit later
				if (!rx_sync)
				begin
					active <= 1'b1;
					baud_cnt <= 16'(`UB_BAUD_DIV / 2 - 1);
					bit_idx <= '0;
				end
			end
			else if (baud_cnt != 16'd0)
			begin
				baud_cnt <= baud_cnt - 16'd1;
			end
			else
			begin
				// Mid-bit sample point
				baud_cnt <= 16'(`UB_BAUD_DIV - 1);
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd0)
				begin
					// Glitch, start bit gone by mid-bit
					if (rx_sync)
						active <= 1'b0;
				end
				else if (bit_idx == 4'd9)
				begin
					// Stop bit, drop the byte on a framing error
					active <= 1'b0;
					rx_valid <= rx_sync;
				end
				else
				begin
					// LSB arrives first
					shift_reg <= {rx_sync, shift_reg[7:1]};
				end
			end
		end
	end

	// Byte stays put until the next frame's first data bit
	assign rx_byte = shift_reg;

	// One strobe per byte, never back to back
	assert property (@(posedge clk_12MHz) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps
`include "uniboard_defs.svh"

module uart_tx (
	input logic clk_12MHz,
	input logic reset,
	input uniboard_pkg::byte_t tx_byte,
	input logic send,
	output logic busy,
	output logic tx
);

	// Stop, data, start; shifted out from bit 0
	logic [9:0] frame;
	logic [3:0] bit_cnt;
	logic [15:0] baud_cnt;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			tx <= 1'b1;
			bit_cnt <= '0;
			baud_cnt <= '0;
		end
		else if (!busy)
		begin
			tx <= 1'b1;
			if (send)
			begin
				busy <= 1'b1;
				frame <= {1'b1, tx_byte, 1'b0};
				bit_cnt <= '0;
				baud_cnt <= '0;
			end
		end
		else if (baud_cnt != 16'd0)
		begin
			baud_cnt <= baud_cnt - 16'd1;
		end
		else if (bit_cnt == 4'd10)
		begin
			// Stop bit has had its full time
			busy <= 1'b0;
		end
		else
		begin
			tx <= frame[0];
			frame <= {1'b1, frame[9:1]};
			bit_cnt <= bit_cnt + 4'd1;
			baud_cnt <= 16'(`UB_BAUD_DIV - 1);
		end
	end

endmodule

// ==== src/uniboard_defs.svh ====
`ifndef UNIBOARD_DEFS_SVH
`define UNIBOARD_DEFS_SVH

// Clock cycles per UART bit at 12 MHz
`define UB_BAUD_DIV 12

// Frame delimiters and escape
`define UB_START_BYTE 8'h01
`define UB_END_BYTE 8'h17
`define UB_ESC_BYTE 8'h1B

// Largest frame body, header plus address plus four data bytes
`define UB_FRAME_BYTES 6

// Peripheral number answered by the motor PWM
`define UB_PWM_PERIPH 7'd2

// Clock cycles per PWM counter step
`define UB_PWM_DIV 4

`endif

// ==== src/uniboard_pkg.sv ====
package uniboard_pkg;

	// One byte on the UART or in a frame
	typedef logic [7:0] byte_t;

	// Peripheral number, low seven bits of the first body byte
	typedef logic [6:0] periph_t;

	typedef logic [7:0] reg_addr_t;

	// Register value, byte 0 in the low bits
	typedef logic [31:0] reg_data_t;

	// Register size in bytes, 0 to 4
	typedef logic [2:0] reg_size_t;

	typedef enum logic [1:0] {
		dec_hunt,
		dec_body,
		dec_escaped,
		dec_request
	} decoder_state_t;

	typedef enum logic [3:0] {
		eng_idle,
		eng_ack,
		eng_wr_setup,
		eng_wr_sel1,
		eng_wr_sel2,
		eng_wr_gap,
		eng_rd_setup,
		eng_rd_sel1,
		eng_rd_sel2,
		eng_reply,
		eng_release
	} engine_state_t;

	typedef enum logic [2:0] {
		enc_idle,
		enc_pick,
		enc_send,
		enc_drain,
		enc_ack
	} encoder_state_t;

endpackage

// ==== src/uniboard_top.sv ====
`timescale 1ns/100ps

module uniboard_top (
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx,
	output logic motor_pwm_l,
	output logic motor_pwm_r
);

	uniboard_pkg::byte_t rx_byte;
	logic rx_valid;
	logic cmd_req;
	logic cmd_ack;
	logic cmd_read;
	uniboard_pkg::periph_t cmd_periph;
	uniboard_pkg::reg_addr_t cmd_addr;
	uniboard_pkg::reg_data_t cmd_data;
	uniboard_pkg::periph_t bus_periph;
	uniboard_pkg::reg_addr_t bus_addr;
	uniboard_pkg::reg_data_t bus_wdata;
	logic bus_rw;
	logic bus_select;
	uniboard_pkg::reg_data_t bus_rdata;
	uniboard_pkg::reg_size_t bus_size;
	uniboard_pkg::reg_data_t pwm_rdata;
	uniboard_pkg::reg_size_t pwm_size;
	logic reply_req;
	logic reply_ack;
	uniboard_pkg::byte_t reply_hdr0;
	uniboard_pkg::reg_addr_t reply_addr;
	uniboard_pkg::reg_data_t reply_data;
	uniboard_pkg::reg_size_t reply_size;
	uniboard_pkg::byte_t tx_byte;
	logic send;
	logic busy;

	uart_rx receiver (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx(uart_rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	frame_decoder decoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data)
	);

	command_engine engine (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.bus_periph(bus_periph),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_rw(bus_rw),
		.bus_select(bus_select),
		.bus_rdata(bus_rdata),
		.bus_size(bus_size),
		.reply_req(reply_req),
		.reply_ack(reply_ack),
		.reply_hdr0(reply_hdr0),
		.reply_addr(reply_addr),
		.reply_data(reply_data),
		.reply_size(reply_size)
	);

	reply_encoder encoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.reply_req(reply_req),
		.reply_ack(reply_ack),
		.reply_hdr0(reply_hdr0),
		.reply_addr(reply_addr),
		.reply_data(reply_data),
		.reply_size(reply_size),
		.tx_byte(tx_byte),
		.send(send),
		.busy(busy)
	);

	uart_tx transmitter (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.tx_byte(tx_byte),
		.send(send),
		.busy(busy),
		.tx(uart_tx)
	);

	pwm_peripheral motor_pwm (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.bus_periph(bus_periph),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_rw(bus_rw),
		.bus_select(bus_select),
		.bus_rdata(pwm_rdata),
		.bus_size(pwm_size),
		.pwm_left(motor_pwm_l),
		.pwm_right(motor_pwm_r)
	);

	// Read-bus OR, a single term with one peripheral
	// Unmapped numbers see zero data and zero size
	assign bus_rdata = pwm_rdata;
	assign bus_size = pwm_size;

endmodule

// ==== vlog.f ====
+incdir+src
src/uniboard_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/frame_decoder.sv
src/command_engine.sv
src/reply_encoder.sv
src/pwm_peripheral.sv
src/uniboard_top.sv
bench/uniboard_tb.sv
